/* hdl/corr_settings.svh */
`ifndef CORR_SETTINGS_SVH
`define CORR_SETTINGS_SVH

// --------------------------------------------------
// Correlator line geometry
// --------------------------------------------------
`define CORR_NUM_LINES 8
`define CORR_START_W 20
`define CORR_LEN_W 20
`define CORR_INC_W 12

// --------------------------------------------------
// APB byte offsets
// --------------------------------------------------
`define CORR_ADDR_CMD 12'h000
`define CORR_ADDR_STATUS 12'h004
`define CORR_ADDR_LINE_BASE 12'h100
// Each line window holds 16 word slots, nine of them are fields
`define CORR_LINE_SHIFT 6

`endif

/* hdl/corr_cmd_pkg.sv */
package corr_cmd_pkg;

	// Opcode taken from the low nibble of a command byte
	typedef enum logic [3:0] {
		op_clear          = 4'd0,
		op_set_line       = 4'd1,
		op_set_leds       = 4'd2,
		op_set_baud       = 4'd3,
		op_set_delay      = 4'd4, // Codes 4 to 7, low bits carry the slot
		op_set_freq_div   = 4'd8,
		op_set_voltage    = 4'd9,
		op_enable_test    = 4'd12,
		op_enable_capture = 4'd13,
		op_none           = 4'd15
	} cmd_op_e;

	typedef logic [7:0] line_sel_t;
	typedef logic [3:0] cmd_arg_t;
	typedef logic [1:0] cmd_slot_t;

	// Global mode state as seen on the status word
	typedef struct packed {
		logic [7:0] rsvd;
		logic [7:0] order;
		logic [3:0] baud;
		logic       extra;
		logic       timestamp_reset;
		logic       external_clock;
		logic       integrating;
		line_sel_t  line;
	} status_t;

	function automatic cmd_op_e decode_op(logic [3:0] code);
		case (code)
			4'd0: return op_clear;
			4'd1: return op_set_line;
			4'd2: return op_set_leds;
			4'd3: return op_set_baud;
			4'd4, 4'd5, 4'd6, 4'd7: return op_set_delay;
			4'd8: return op_set_freq_div;
			4'd9: return op_set_voltage;
			4'd12: return op_enable_test;
			4'd13: return op_enable_capture;
			default: return op_none;
		endcase
	endfunction

endpackage

/* hdl/corr_cfg_pkg.sv */
`include "corr_settings.svh"

package corr_cfg_pkg;

	// Word index inside one line window
	typedef enum logic [3:0] {
		fld_voltage     = 4'd0,
		fld_test        = 4'd1,
		fld_leds        = 4'd2,
		fld_cross_start = 4'd3,
		fld_auto_start  = 4'd4,
		fld_cross_len   = 4'd5,
		fld_auto_len    = 4'd6,
		fld_cross_inc   = 4'd7,
		fld_auto_inc    = 4'd8
	} cfg_field_e;

	typedef struct packed {
		logic [7:0]               voltage;
		logic [7:0]               test;    // Bit 7 steers delay writes
		logic [7:0]               leds;
		logic [`CORR_START_W-1:0] cross_start;
		logic [`CORR_START_W-1:0] auto_start;
		logic [`CORR_LEN_W-1:0]   cross_len;
		logic [`CORR_LEN_W-1:0]   auto_len;
		logic [`CORR_INC_W-1:0]   cross_inc;
		logic [`CORR_INC_W-1:0]   auto_inc;
	} line_cfg_t;

	localparam line_cfg_t line_cfg_rst = '{
		cross_inc: `CORR_INC_W'(1),
		auto_inc: `CORR_INC_W'(1),
		default: '0
	};

endpackage

/* hdl/cfg_cmd_if.sv */
interface cfg_cmd_if;
	import corr_cmd_pkg::*;

	logic      valid;
	cmd_op_e   op;
	line_sel_t line;  // Line selected when the byte was decoded
	logic      extra;
	cmd_arg_t  arg;   // High nibble of the command byte
	cmd_slot_t slot;

	modport decoder (
		output valid,
		output op,
		output line,
		output extra,
		output arg,
		output slot
	);

	modport bank (
		input valid,
		input op,
		input line,
		input extra,
		input arg,
		input slot
	);

endinterface

/* hdl/apb_cmd_port.sv */
`include "corr_settings.svh"

module apb_cmd_port (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     psel,
	input  logic                     penable,
	input  logic                     pwrite,
	input  logic [11:0]              paddr,
	input  logic [31:0]              pwdata,
	output logic [31:0]              prdata,
	output logic                     pready,
	output logic                     pslverr,
	output logic                     byte_valid,
	output logic [7:0]               cmd_byte,
	input  logic [31:0]              status_word,
	output corr_cmd_pkg::line_sel_t  rd_line,
	output corr_cfg_pkg::cfg_field_e rd_field,
	input  logic [31:0]              rd_data
);
	import corr_cfg_pkg::*;

	logic [1:0]  in_flight;
	logic        access;
	logic        wr_cmd;
	logic        is_cmd;
	logic        is_status;
	logic        is_line;
	logic [11:0] line_off;
	logic [11:0] line_num;
	logic [3:0]  word_idx;

	// --------------------------------------------------
	// Address decode
	// --------------------------------------------------
	assign is_cmd = (paddr == `CORR_ADDR_CMD);
	assign is_status = (paddr == `CORR_ADDR_STATUS);
	assign line_off = paddr - `CORR_ADDR_LINE_BASE;
	assign line_num = line_off >> `CORR_LINE_SHIFT;
	assign word_idx = line_off[`CORR_LINE_SHIFT-1:2];
	assign is_line = (paddr >= `CORR_ADDR_LINE_BASE) && (line_num < `CORR_NUM_LINES)
		&& (word_idx <= fld_auto_inc);

	assign rd_line = line_num[7:0];
	assign rd_field = cfg_field_e'(word_idx);

	// --------------------------------------------------
	// Handshake
	// --------------------------------------------------
	assign access = psel && penable;
	assign pready = (in_flight == 2'b00); // Stall until the bank has taken the update
	assign wr_cmd = access && pwrite && is_cmd && pready;
	assign pslverr = access && pready && (pwrite ? !is_cmd : !(is_status || is_line));

	always_comb begin
		prdata = '0;
		if (!pwrite && is_status)
			prdata = status_word;
		else if (!pwrite && is_line)
			prdata = rd_data;
	end

	// Bit 0 marks the decode cycle, bit 1 the bank update cycle
	always_ff @(posedge clk) begin
		if (!rst_n)
			in_flight <= 2'b00;
		else
			in_flight <= {in_flight[0], wr_cmd};
	end

	always_ff @(posedge clk) begin
		if (wr_cmd)
			cmd_byte <= pwdata[7:0];
	end

	assign byte_valid = in_flight[0];

	assert property (@(posedge clk) disable iff (!rst_n) byte_valid |=> !byte_valid);
	assert property (@(posedge clk) disable iff (!rst_n) penable |-> psel);

endmodule

/* hdl/cmd_decoder.sv */
module cmd_decoder (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        byte_valid,
	input  logic [7:0]  cmd_byte,
	cfg_cmd_if.decoder  cmd,
	output logic [31:0] status_word,
	output logic        integrating,
	output logic        external_clock,
	output logic        timestamp_reset,
	output logic [3:0]  baud_rate
);
	import corr_cmd_pkg::*;

	cmd_op_e    op;
	logic       forward;
	line_sel_t  cur_line;
	logic       extra_commands;
	logic [7:0] order;
	status_t    status;

	assign op = decode_op(cmd_byte[3:0]);

	// Ops that touch a single line go on to the bank
	always_comb begin
		case (op)
			op_set_line, op_set_baud, op_enable_capture, op_none: forward = 1'b0;
			default: forward = 1'b1;
		endcase
	end

	// --------------------------------------------------
	// Global mode state
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cur_line <= '0;
			extra_commands <= 1'b0;
			integrating <= 1'b0;
			external_clock <= 1'b0;
			timestamp_reset <= 1'b1;
			baud_rate <= '0;
			order <= '0;
		end else if (byte_valid) begin
			case (op)
				op_set_line: cur_line[{cmd_byte[7:6], 1'b0} +: 2] <= cmd_byte[5:4];
				op_enable_capture: begin
					integrating <= cmd_byte[4];
					external_clock <= cmd_byte[5];
					timestamp_reset <= cmd_byte[6];
					extra_commands <= cmd_byte[7];
				end
				op_set_baud: begin
					if (extra_commands)
						order[cmd_byte[7:5]] <= cmd_byte[4]; // Bits 7 to 5 pick the order bit
					else
						baud_rate <= cmd_byte[7:4];
				end
				default: ;
			endcase
		end
	end

	// --------------------------------------------------
	// Per-line operation output
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n)
			cmd.valid <= 1'b0;
		else
			cmd.valid <= byte_valid && forward;
	end

	always_ff @(posedge clk) begin
		if (byte_valid) begin
			cmd.op <= op;
			cmd.line <= cur_line;
			cmd.extra <= extra_commands;
			cmd.arg <= cmd_byte[7:4];
			cmd.slot <= cmd_byte[1:0];
		end
	end

	always_comb begin
		status = '0;
		status.line = cur_line;
		status.integrating = integrating;
		status.external_clock = external_clock;
		status.timestamp_reset = timestamp_reset;
		status.extra = extra_commands;
		status.baud = baud_rate;
		status.order = order;
	end

	assign status_word = status;

	// A forwarded operation always carries a decoded opcode
	assert property (@(posedge clk) disable iff (!rst_n) cmd.valid |-> cmd.op != op_none);

endmodule

/* hdl/line_config_bank.sv */
`include "corr_settings.svh"

module line_config_bank (
	input  logic                     clk,
	input  logic                     rst_n,
	cfg_cmd_if.bank                  cmd,
	input  corr_cmd_pkg::line_sel_t  rd_line,
	input  corr_cfg_pkg::cfg_field_e rd_field,
	output logic [31:0]              rd_data
);
	import corr_cmd_pkg::*;
	import corr_cfg_pkg::*;

	localparam int num_lines = `CORR_NUM_LINES;
	localparam int idx_w = $clog2(num_lines);

	line_cfg_t        cfg [num_lines];
	line_cfg_t        cur;
	line_cfg_t        upd;
	line_cfg_t        rd_cfg;
	logic             wr_hit;
	logic [idx_w-1:0] wr_idx;
	logic [3:0]       delay_off;
	logic [3:0]       div_off;

	assign wr_hit = cmd.valid && (cmd.line < num_lines);
	assign wr_idx = cmd.line[idx_w-1:0];
	assign cur = cfg[wr_idx];
	assign delay_off = 4'(cmd.slot) * 4'd3;
	assign div_off = cmd.arg[2] ? 4'd14 : 4'd12; // Divider bits sit above the delay bits

	// --------------------------------------------------
	// Next value of the addressed line
	// --------------------------------------------------
	always_comb begin
		upd = cur;
		case (cmd.op)
			op_clear: begin
				upd.cross_start = '0;
				upd.auto_start = '0;
			end
			op_set_leds: upd.leds[{cmd.extra, 2'b00} +: 4] = cmd.arg;
			op_enable_test: upd.test[{cmd.extra, 2'b00} +: 4] = cmd.arg;
			op_set_voltage: upd.voltage[{cmd.arg[3:2], 1'b0} +: 2] = cmd.arg[1:0];
			op_set_delay: begin
				// Test bit 7 and the extra flag pick the target field
				if (cur.test[7] && cmd.extra) begin
					if (cmd.arg[3])
						upd.auto_inc[delay_off +: 3] = cmd.arg[2:0];
					else
						upd.cross_inc[delay_off +: 3] = cmd.arg[2:0];
				end else if (cur.test[7]) begin
					if (cmd.arg[3])
						upd.auto_start[delay_off +: 3] = cmd.arg[2:0];
					else
						upd.cross_start[delay_off +: 3] = cmd.arg[2:0];
				end else if (cmd.extra) begin
					if (cmd.arg[3])
						upd.auto_len[delay_off +: 3] = cmd.arg[2:0];
					else
						upd.cross_len[delay_off +: 3] = cmd.arg[2:0];
				end
			end
			op_set_freq_div: begin
				if (cmd.extra) begin
					if (cmd.arg[3])
						upd.auto_len[div_off +: 2] = cmd.arg[1:0];
					else
						upd.cross_len[div_off +: 2] = cmd.arg[1:0];
				end else begin
					if (cmd.arg[3])
						upd.auto_start[div_off +: 2] = cmd.arg[1:0];
					else
						upd.cross_start[div_off +: 2] = cmd.arg[1:0];
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < num_lines; i++)
				cfg[i] <= line_cfg_rst;
		end else if (wr_hit) begin
			cfg[wr_idx] <= upd;
		end
	end

	// --------------------------------------------------
	// Readback
	// --------------------------------------------------
	assign rd_cfg = cfg[rd_line[idx_w-1:0]];

	always_comb begin
		rd_data = '0;
		if (rd_line < num_lines) begin
			case (rd_field)
				fld_voltage: rd_data = 32'(rd_cfg.voltage);
				fld_test: rd_data = 32'(rd_cfg.test);
				fld_leds: rd_data = 32'(rd_cfg.leds);
				fld_cross_start: rd_data = 32'(rd_cfg.cross_start);
				fld_auto_start: rd_data = 32'(rd_cfg.auto_start);
				fld_cross_len: rd_data = 32'(rd_cfg.cross_len);
				fld_auto_len: rd_data = 32'(rd_cfg.auto_len);
				fld_cross_inc: rd_data = 32'(rd_cfg.cross_inc);
				fld_auto_inc: rd_data = 32'(rd_cfg.auto_inc);
				default: ;
			endcase
		end
	end

endmodule

/* hdl/corr_cmd_top.sv */
module corr_cmd_top (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [11:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	output logic        integrating,
	output logic        external_clock,
	output logic        timestamp_reset,
	output logic [3:0]  baud_rate
);
	import corr_cmd_pkg::*;
	import corr_cfg_pkg::*;

	logic        byte_valid;
	logic [7:0]  cmd_byte;
	logic [31:0] status_word;
	line_sel_t   rd_line;
	cfg_field_e  rd_field;
	logic [31:0] rd_data;

	cfg_cmd_if cmd_if ();

	apb_cmd_port port_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.byte_valid  (byte_valid),
		.cmd_byte    (cmd_byte),
		.status_word (status_word),
		.rd_line     (rd_line),
		.rd_field    (rd_field),
		.rd_data     (rd_data)
	);

	cmd_decoder dec_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.byte_valid      (byte_valid),
		.cmd_byte        (cmd_byte),
		.cmd             (cmd_if.decoder),
		.status_word     (status_word),
		.integrating     (integrating),
		.external_clock  (external_clock),
		.timestamp_reset (timestamp_reset),
		.baud_rate       (baud_rate)
	);

	line_config_bank bank_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.cmd      (cmd_if.bank),
		.rd_line  (rd_line),
		.rd_field (rd_field),
		.rd_data  (rd_data)
	);

endmodule

/* tb/corr_cmd_tb.sv */
`include "corr_settings.svh"

module corr_cmd_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import corr_cmd_pkg::*;
	import corr_cfg_pkg::*;

	localparam int num_lines = `CORR_NUM_LINES;
	localparam int num_fields = 9;
	localparam int max_wait = 20;

	logic        clk;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [11:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        integrating;
	logic        external_clock;
	logic        timestamp_reset;
	logic [3:0]  baud_rate;

	// Reference model of the global mode state and the line registers
	logic [7:0]  m_line;
	logic        m_extra;
	logic        m_integ;
	logic        m_ext_clk;
	logic        m_ts_reset;
	logic [3:0]  m_baud;
	logic [7:0]  m_order;
	logic [31:0] m_cfg [num_lines][num_fields];
	string       fld_names [num_fields];

	int          checks;
	int          errors;
	int          timeouts;
	bit          aborted;
	logic [31:0] lcg_state;

	corr_cmd_top dut_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.psel            (psel),
		.penable         (penable),
		.pwrite          (pwrite),
		.paddr           (paddr),
		.pwdata          (pwdata),
		.prdata          (prdata),
		.pready          (pready),
		.pslverr         (pslverr),
		.integrating     (integrating),
		.external_clock  (external_clock),
		.timestamp_reset (timestamp_reset),
		.baud_rate       (baud_rate)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [7:0] lcg_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16];
	endfunction

	function automatic logic [11:0] line_addr(input int ln, input int f);
		return 12'(`CORR_ADDR_LINE_BASE + (ln << `CORR_LINE_SHIFT) + 4 * f);
	endfunction

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------
	task automatic init_model();
		m_line = '0;
		m_extra = 1'b0;
		m_integ = 1'b0;
		m_ext_clk = 1'b0;
		m_ts_reset = 1'b1;
		m_baud = '0;
		m_order = '0;
		for (int ln = 0; ln < num_lines; ln++) begin
			for (int f = 0; f < num_fields; f++)
				m_cfg[ln][f] = (f == fld_cross_inc || f == fld_auto_inc) ? 32'd1 : 32'd0;
		end
		fld_names = '{"voltage", "test", "leds", "cross_start", "auto_start",
			"cross_len", "auto_len", "cross_inc", "auto_inc"};
	endtask

	task automatic write_field_bits(input int ln, input int fld, input int off, input int width,
			input logic [3:0] val);
		logic [31:0] mask;
		mask = ((32'd1 << width) - 32'd1) << off;
		m_cfg[ln][fld] = (m_cfg[ln][fld] & ~mask) | ((32'(val) << off) & mask);
	endtask

	task automatic apply_line_op(input int ln, input logic [7:0] b);
		logic [3:0] arg;
		int         nib;
		int         fld;
		arg = b[7:4];
		nib = m_extra ? 4 : 0;
		fld = -1;
		case (b[3:0])
			op_clear: begin
				m_cfg[ln][fld_cross_start] = '0;
				m_cfg[ln][fld_auto_start] = '0;
			end
			op_set_leds: write_field_bits(ln, fld_leds, nib, 4, arg);
			op_enable_test: write_field_bits(ln, fld_test, nib, 4, arg);
			op_set_voltage: write_field_bits(ln, fld_voltage, 2 * int'(arg[3:2]), 2, arg);
			4'd4, 4'd5, 4'd6, 4'd7: begin
				if (m_cfg[ln][fld_test][7] && m_extra)
					fld = arg[3] ? fld_auto_inc : fld_cross_inc;
				else if (m_cfg[ln][fld_test][7])
					fld = arg[3] ? fld_auto_start : fld_cross_start;
				else if (m_extra)
					fld = arg[3] ? fld_auto_len : fld_cross_len;
				if (fld >= 0)
					write_field_bits(ln, fld, 3 * int'(b[1:0]), 3, {1'b0, arg[2:0]});
			end
			op_set_freq_div: begin
				if (m_extra)
					fld = arg[3] ? fld_auto_len : fld_cross_len;
				else
					fld = arg[3] ? fld_auto_start : fld_cross_start;
				write_field_bits(ln, fld, arg[2] ? 14 : 12, 2, arg);
			end
			default: ;
		endcase
	endtask

	task automatic apply_to_model(input logic [7:0] b);
		int pos;
		pos = 2 * int'(b[7:6]);
		case (b[3:0])
			op_set_line: begin
				m_line[pos] = b[4];
				m_line[pos + 1] = b[5];
			end
			op_enable_capture: begin
				m_integ = b[4];
				m_ext_clk = b[5];
				m_ts_reset = b[6];
				m_extra = b[7];
			end
			op_set_baud: begin
				if (m_extra)
					m_order[b[7:5]] = b[4];
				else
					m_baud = b[7:4];
			end
			default: begin
				if (int'(m_line) < num_lines) // Lines past the bank are dropped
					apply_line_op(int'(m_line), b);
			end
		endcase
	endtask

	// --------------------------------------------------
	// APB driver and checks
	// --------------------------------------------------
	task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		int waited;
		rdata = '0;
		err = 1'b0;
		if (aborted)
			return;
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		waited = 0;
		while (!pready && waited < max_wait) begin
			@(negedge clk);
			waited++;
		end
		if (!pready) begin
			timeouts++;
			aborted = 1'b1;
			$display("Timeout at %0t: pready stayed low for %0d cycles at address 0x%03h",
				$time, max_wait, addr);
		end
		rdata = prdata; // Sampled mid-cycle while the access is still open
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(input logic [11:0] addr, input logic [31:0] wdata, output logic err);
		logic [31:0] unused;
		apb_xfer(1'b1, addr, wdata, unused, err);
	endtask

	task automatic apb_read(input logic [11:0] addr, output logic [31:0] rdata, output logic err);
		apb_xfer(1'b0, addr, 32'd0, rdata, err);
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (aborted)
			return;
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Fail at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
		end
	endtask

	task automatic send_cmd(input logic [7:0] b);
		logic err;
		apb_write(`CORR_ADDR_CMD, {24'h0, b}, err);
		compare_value("pslverr", 32'(err), 32'd0);
		apply_to_model(b);
	endtask

	task automatic verify_line(input int ln);
		logic [31:0] data;
		logic        err;
		for (int f = 0; f < num_fields; f++) begin
			apb_read(line_addr(ln, f), data, err);
			compare_value("pslverr", 32'(err), 32'd0);
			compare_value($sformatf("line %0d %s", ln, fld_names[f]), data, m_cfg[ln][f]);
		end
	endtask

	task automatic expect_status();
		logic [31:0] data;
		logic        err;
		logic [31:0] exp;
		exp = {8'h00, m_order, m_baud, m_extra, m_ts_reset, m_ext_clk, m_integ, m_line};
		apb_read(`CORR_ADDR_STATUS, data, err);
		compare_value("pslverr", 32'(err), 32'd0);
		compare_value("status", data, exp);
		@(negedge clk);
		compare_value("integrating", 32'(integrating), 32'(m_integ));
		compare_value("external_clock", 32'(external_clock), 32'(m_ext_clk));
		compare_value("timestamp_reset", 32'(timestamp_reset), 32'(m_ts_reset));
		compare_value("baud_rate", 32'(baud_rate), 32'(m_baud));
	endtask

	task automatic verify_model();
		for (int ln = 0; ln < num_lines; ln++)
			verify_line(ln);
		expect_status();
	endtask

	// Four set_line bytes, two bits each
	task automatic select_line(input logic [7:0] n);
		for (int pos = 0; pos < 4; pos++)
			send_cmd({2'(pos), n[2 * pos +: 2], op_set_line});
	endtask

	task automatic set_extra(input logic e);
		send_cmd({e, m_ts_reset, m_ext_clk, m_integ, op_enable_capture});
	endtask

	// --------------------------------------------------
	// Directed tests
	// --------------------------------------------------
	task automatic reset_values();
		verify_model();
	endtask

	task automatic mode_state();
		select_line(8'd5);
		send_cmd({4'hA, op_set_baud});
		send_cmd({1'b1, 1'b0, 1'b1, 1'b1, op_enable_capture});
		send_cmd({3'd5, 1'b1, op_set_baud}); // Order bits now that extra is set
		send_cmd({3'd0, 1'b1, op_set_baud});
		send_cmd({3'd7, 1'b1, op_set_baud});
		send_cmd({3'd0, 1'b0, op_set_baud});
		expect_status();
		send_cmd({1'b0, 1'b1, 1'b0, 1'b1, op_enable_capture});
		send_cmd({4'h3, op_set_baud});
		select_line(8'hC6);
		expect_status();
		select_line(8'd0);
		expect_status();
	endtask

	task automatic nibble_fields();
		for (int ln = 1; ln < num_lines; ln += 2) begin
			select_line(8'(ln));
			set_extra(1'b0);
			send_cmd({4'(ln + 2), op_enable_test});
			send_cmd({4'(ln * 3), op_set_leds});
			set_extra(1'b1);
			send_cmd({4'(ln + 5), op_enable_test});
			send_cmd({4'(15 - ln), op_set_leds});
			for (int s = 0; s < 4; s++)
				send_cmd({2'(s), 2'(ln + s), op_set_voltage});
		end
		verify_model();
		select_line(8'(num_lines));
		send_cmd({4'h9, op_set_leds});
		send_cmd({4'h6, op_enable_test});
		send_cmd({4'hE, op_set_voltage});
		verify_model();
		set_extra(1'b0);
		select_line(8'd0);
	endtask

	task automatic delay_routing();
		logic [3:0] arg;
		select_line(8'd2);
		for (int t7 = 0; t7 < 2; t7++) begin
			for (int e = 0; e < 2; e++) begin
				set_extra(1'b1);
				send_cmd({t7 ? 4'h8 : 4'h0, op_enable_test}); // High nibble holds test bit 7
				set_extra(1'(e));
				for (int s = 0; s < 4; s++) begin
					arg = 4'(s * 5 + t7 * 2 + e + 3);
					send_cmd({arg, 2'b01, 2'(s)});
				end
				send_cmd({4'b0101, op_set_freq_div});
				send_cmd({4'b1010, op_set_freq_div});
				verify_line(2);
			end
		end
		send_cmd({4'h0, op_clear});
		verify_line(2);
		expect_status();
	endtask

	task automatic bus_errors();
		logic [31:0] data;
		logic        err;
		apb_write(`CORR_ADDR_STATUS, 32'h0000_00fd, err);
		compare_value("pslverr", 32'(err), 32'd1);
		apb_write(line_addr(1, 2), 32'h0000_0055, err);
		compare_value("pslverr", 32'(err), 32'd1);
		apb_read(12'h008, data, err);
		compare_value("pslverr", 32'(err), 32'd1);
		apb_read(line_addr(0, num_fields), data, err); // Word past the last field
		compare_value("pslverr", 32'(err), 32'd1);
		apb_read(line_addr(num_lines, 0), data, err);
		compare_value("pslverr", 32'(err), 32'd1);
		verify_model();
	endtask

	task automatic random_stream();
		logic [7:0] b;
		for (int i = 0; i < 200; i++) begin
			b = lcg_byte();
			send_cmd(b);
			verify_line(int'(m_line) % num_lines);
			expect_status();
		end
	endtask

	initial begin
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		checks = 0;
		errors = 0;
		timeouts = 0;
		aborted = 1'b0;
		lcg_state = 32'd56;
		init_model();
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		reset_values();
		mode_state();
		nibble_fields();
		delay_routing();
		bus_errors();
		random_stream();

		$display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* build.f */
+incdir+hdl
hdl/corr_cmd_pkg.sv
hdl/corr_cfg_pkg.sv
hdl/cfg_cmd_if.sv
hdl/apb_cmd_port.sv
hdl/cmd_decoder.sv
hdl/line_config_bank.sv
hdl/corr_cmd_top.sv
tb/corr_cmd_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then scan the log for failure
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module corr_cmd_tb \
	-f build.f -o corr_cmd_sim > build.log 2>&1 \
	&& ./obj_dir/corr_cmd_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2> /dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "Some tests failed" sim.log && { echo "Simulation reported failure"; exit 1; }
echo "Simulation passed"
